//--- design/cpu_pkg.sv
package cpu_pkg;

localparam logic [15:0] VECTOR_RESET = 16'hfffc;
localparam int MOP_DEPTH = 64;
localparam int MOP_AW = $clog2(MOP_DEPTH);

// Bit positions in P, bit 5 is tied high
localparam int FLAG_C = 0;
localparam int FLAG_Z = 1;
localparam int FLAG_N = 7;

typedef enum logic [1:0] {ALU_ADD = 2'd0, ALU_AND = 2'd1, ALU_EOR = 2'd2, ALU_PASS = 2'd3} alu_op_t;
typedef enum logic [1:0] {CIN_C = 2'd0, CIN_ZERO = 2'd1, CIN_ONE = 2'd2} cin_t;
typedef enum logic [1:0] {SB_DL = 2'd0, SB_A = 2'd1, SB_X = 2'd2, SB_ALU = 2'd3} sb_src_t;
// AD_ABS puts the live byte on top of the latched one
typedef enum logic [1:0] {AD_PC = 2'd0, AD_ABS = 2'd1, AD_VEC_LO = 2'd2, AD_VEC_HI = 2'd3} ad_src_t;
typedef enum logic [1:0] {SEQ_FETCH = 2'd0, SEQ_NEXT = 2'd1, SEQ_DISPATCH = 2'd2} seq_t;

typedef struct packed {
	alu_op_t alu;
	cin_t cin;
	sb_src_t sb;
	logic ld_a;
	logic ld_x;
	logic ld_p;
	ad_src_t ad;
	logic ld_ad;
	logic pc_inc;
	logic pc_ld;
	logic dl_hold;
	logic wr;
	seq_t seq;
	// Opcode fetch, seen outside as sync
	logic disp;
} mop_t;

typedef struct packed {
	logic [15:0] addr;
	logic [7:0] data;
	logic rw;
} cpu_bus_t;

typedef struct packed {
	logic [15:0] pc;
	logic [7:0] a;
	logic [7:0] x;
	logic [7:0] p;
} dbg_snapshot_t;

// Microcode entry points
localparam logic [MOP_AW-1:0] UC_RESET = 6'd0;
localparam logic [MOP_AW-1:0] UC_FETCH = 6'd2;
localparam logic [MOP_AW-1:0] UC_NOP = 6'd3;
localparam logic [MOP_AW-1:0] UC_LDA = 6'd4;
localparam logic [MOP_AW-1:0] UC_LDX = 6'd5;
localparam logic [MOP_AW-1:0] UC_ADC = 6'd6;
localparam logic [MOP_AW-1:0] UC_AND = 6'd7;
localparam logic [MOP_AW-1:0] UC_EOR = 6'd8;
localparam logic [MOP_AW-1:0] UC_CLC = 6'd9;
localparam logic [MOP_AW-1:0] UC_SEC = 6'd10;
localparam logic [MOP_AW-1:0] UC_JMP = 6'd11;
localparam logic [MOP_AW-1:0] UC_STA = 6'd13;
localparam logic [MOP_AW-1:0] UC_STX = 6'd16;
localparam logic [MOP_AW-1:0] MOP_USED = 6'd19;

endpackage

//--- design/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
	input logic [7:0] a_in,
	input logic [7:0] b_in,
	input logic carry_in,
	input cpu_pkg::alu_op_t op,
	output logic [7:0] result,
	output logic carry_out
);

import cpu_pkg::*;

logic [8:0] sum;

assign sum = {1'b0, a_in} + {1'b0, b_in} + {8'h00, carry_in};

always_comb begin
	carry_out = 1'b0;
	case (op)
	ALU_ADD: begin
		result = sum[7:0];
		// Only the adder produces a carry
		carry_out = sum[8];
	end
	ALU_AND:
		result = a_in & b_in;
	ALU_EOR:
		result = a_in ^ b_in;
	default:
		result = b_in;
	endcase
end

endmodule

//--- design/mop_sequencer.sv
`timescale 1ns/1ps

module mop_sequencer (
	input logic clk, n_reset,
	input logic ready, halt,
	input logic sync,
	input logic [7:0] opcode,
	output cpu_pkg::mop_t mop,
	output logic run,
	output logic [cpu_pkg::MOP_AW-1:0] mop_addr
);

import cpu_pkg::*;

logic [MOP_AW-1:0] disp_addr, next_addr;

// Reads stall on ready, halt only bites at an opcode fetch
assign run = mop.wr | (ready & ~(halt & sync));

// alu cin sb a/x/p ad ld_ad/pc_inc/pc_ld/dl_hold wr seq disp
always_comb
	case (mop_addr)
	UC_RESET: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_VEC_HI, 4'b1000, 1'b0, SEQ_NEXT, 1'b0};
	UC_RESET + 1'b1: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_ABS, 4'b1010, 1'b0, SEQ_FETCH, 1'b0};
	UC_FETCH: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b1100, 1'b0, SEQ_DISPATCH, 1'b1};
	UC_NOP: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b0000, 1'b0, SEQ_FETCH, 1'b0};
	UC_LDA: mop = {ALU_PASS, CIN_C, SB_DL, 3'b100, AD_PC, 4'b1100, 1'b0, SEQ_FETCH, 1'b0};
	UC_LDX: mop = {ALU_PASS, CIN_C, SB_DL, 3'b010, AD_PC, 4'b1100, 1'b0, SEQ_FETCH, 1'b0};
	UC_ADC: mop = {ALU_ADD, CIN_C, SB_ALU, 3'b101, AD_PC, 4'b1100, 1'b0, SEQ_FETCH, 1'b0};
	UC_AND: mop = {ALU_AND, CIN_C, SB_ALU, 3'b100, AD_PC, 4'b1100, 1'b0, SEQ_FETCH, 1'b0};
	UC_EOR: mop = {ALU_EOR, CIN_C, SB_ALU, 3'b100, AD_PC, 4'b1100, 1'b0, SEQ_FETCH, 1'b0};
	UC_CLC: mop = {ALU_PASS, CIN_ZERO, SB_DL, 3'b001, AD_PC, 4'b0000, 1'b0, SEQ_FETCH, 1'b0};
	UC_SEC: mop = {ALU_PASS, CIN_ONE, SB_DL, 3'b001, AD_PC, 4'b0000, 1'b0, SEQ_FETCH, 1'b0};
	UC_JMP: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b1100, 1'b0, SEQ_NEXT, 1'b0};
	UC_JMP + 1'b1: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_ABS, 4'b1010, 1'b0, SEQ_FETCH, 1'b0};
	UC_STA: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b1100, 1'b0, SEQ_NEXT, 1'b0};
	UC_STA + 1'b1: mop = {ALU_ADD, CIN_C, SB_A, 3'b000, AD_ABS, 4'b1000, 1'b0, SEQ_NEXT, 1'b0};
	UC_STA + 2'd2: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b1101, 1'b1, SEQ_FETCH, 1'b0};
	UC_STX: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b1100, 1'b0, SEQ_NEXT, 1'b0};
	UC_STX + 1'b1: mop = {ALU_ADD, CIN_C, SB_X, 3'b000, AD_ABS, 4'b1000, 1'b0, SEQ_NEXT, 1'b0};
	UC_STX + 2'd2: mop = {ALU_ADD, CIN_C, SB_DL, 3'b000, AD_PC, 4'b1101, 1'b1, SEQ_FETCH, 1'b0};
	default: mop = '0;
	endcase

always_comb
	case (opcode)
	8'ha9: disp_addr = UC_LDA;
	8'ha2: disp_addr = UC_LDX;
	8'h69: disp_addr = UC_ADC;
	8'h29: disp_addr = UC_AND;
	8'h49: disp_addr = UC_EOR;
	8'h18: disp_addr = UC_CLC;
	8'h38: disp_addr = UC_SEC;
	8'h4c: disp_addr = UC_JMP;
	8'h8d: disp_addr = UC_STA;
	8'h8e: disp_addr = UC_STX;
	default: disp_addr = UC_NOP;
	endcase

always_comb
	case (mop.seq)
	SEQ_NEXT: next_addr = mop_addr + 1'b1;
	SEQ_DISPATCH: next_addr = disp_addr;
	default: next_addr = UC_FETCH;
	endcase

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		mop_addr <= UC_RESET;
	else if (run)
		mop_addr <= next_addr;

// A dispatch must never land outside the written table
assert property (@(posedge clk) disable iff (!n_reset) run |=> mop_addr < MOP_USED);

endmodule

//--- design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input logic clk, n_reset,
	input cpu_pkg::mop_t mop,
	input logic run,
	input logic [7:0] data_in,
	output cpu_pkg::cpu_bus_t bus,
	output logic sync,
	output logic [7:0] opcode,
	output cpu_pkg::dbg_snapshot_t snapshot
);

import cpu_pkg::*;

logic [7:0] a, x, p;
logic [15:0] pc, ab, ad_next;
logic [7:0] dl, dl_prev, wdata;
logic [7:0] sb, alu_result;
logic alu_cin, alu_cout;

// Transparent unless held, so operands are usable in the cycle they arrive
assign dl = mop.dl_hold ? dl_prev : data_in;
assign opcode = dl;
assign sync = mop.disp;

assign bus = '{addr: ab, data: wdata, rw: ~mop.wr};
// Address register holds the opcode address while halted at a fetch
assign snapshot = '{pc: ab, a: a, x: x, p: p};

always_comb
	case (mop.sb)
	SB_DL: sb = dl;
	SB_A: sb = a;
	SB_X: sb = x;
	default: sb = alu_result;
	endcase

always_comb
	case (mop.cin)
	CIN_ZERO: alu_cin = 1'b0;
	CIN_ONE: alu_cin = 1'b1;
	default: alu_cin = p[FLAG_C];
	endcase

always_comb
	case (mop.ad)
	AD_ABS: ad_next = {dl, dl_prev};
	AD_VEC_LO: ad_next = VECTOR_RESET;
	AD_VEC_HI: ad_next = VECTOR_RESET + 16'd1;
	default: ad_next = pc;
	endcase

cpu_alu alu_inst (
	.a_in(a),
	.b_in(dl),
	.carry_in(alu_cin),
	.op(mop.alu),
	.result(alu_result),
	.carry_out(alu_cout)
);

// Next bus address, chosen one cycle ahead
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		ab <= VECTOR_RESET;
	else if (run && mop.ld_ad)
		ab <= ad_next;

// PC runs one byte ahead of the address register
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		pc <= '0;
	else if (run) begin
		if (mop.pc_ld)
			pc <= ad_next + 16'd1;
		else if (mop.pc_inc)
			pc <= pc + 16'd1;
	end

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		a <= '0;
		x <= '0;
		p <= 8'h20;
	end else if (run) begin
		if (mop.ld_a)
			a <= sb;
		if (mop.ld_x)
			x <= sb;
		if (mop.ld_a || mop.ld_x) begin
			p[FLAG_N] <= sb[7];
			p[FLAG_Z] <= (sb == 8'h00);
		end
		// CLC and SEC pass the forced carry-in straight to C
		if (mop.ld_p)
			p[FLAG_C] <= (mop.alu == ALU_ADD) ? alu_cout : alu_cin;
	end

// Store data comes off the internal bus one cycle ahead of the write
always_ff @(posedge clk)
	if (run) begin
		dl_prev <= dl;
		wdata <= sb;
	end

assert property (@(posedge clk) disable iff (!n_reset) !run |-> bus.rw);

// Only N, Z and C ever change, bit 5 stays set
assert property (@(posedge clk) disable iff (!n_reset) p[5] && (p & 8'h5c) == 8'h00);

endmodule

//--- design/debug_scan.sv
`timescale 1ns/1ps

module debug_scan (
	input logic clk, n_reset,
	input cpu_pkg::dbg_snapshot_t snapshot,
	input logic dbg_load, dbg_shift,
	output logic dbg_dout
);

import cpu_pkg::*;

logic [$bits(dbg_snapshot_t)-1:0] sr;

// Load has priority, shift moves MSB first
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		sr <= '0;
	else if (dbg_load)
		sr <= snapshot;
	else if (dbg_shift)
		sr <= {sr[$bits(sr)-2:0], 1'b0};

assign dbg_dout = sr[$bits(sr)-1];

assert property (@(posedge clk) disable iff (!n_reset) !(dbg_load && dbg_shift))
	else $warning("debug_scan: load and shift together, load taken");

endmodule

//--- design/cpu_system.sv
`timescale 1ns/1ps

module cpu_system (
	input logic clk, n_reset,
	input logic ready, halt,
	input logic [7:0] data_in,
	output cpu_pkg::cpu_bus_t bus,
	output logic sync,
	input logic dbg_load, dbg_shift,
	output logic dbg_dout
);

import cpu_pkg::*;

mop_t mop;
logic run;
logic [7:0] opcode;
dbg_snapshot_t snapshot;

mop_sequencer mop_sequencer_inst (
	.clk(clk),
	.n_reset(n_reset),
	.ready(ready),
	.halt(halt),
	.sync(sync),
	.opcode(opcode),
	.mop(mop),
	.run(run),
	// Micro-address only watched in simulation
	.mop_addr()
);

cpu_core cpu_core_inst (
	.clk(clk),
	.n_reset(n_reset),
	.mop(mop),
	.run(run),
	.data_in(data_in),
	.bus(bus),
	.sync(sync),
	.opcode(opcode),
	.snapshot(snapshot)
);

debug_scan debug_scan_inst (
	.clk(clk),
	.n_reset(n_reset),
	.snapshot(snapshot),
	.dbg_load(dbg_load),
	.dbg_shift(dbg_shift),
	.dbg_dout(dbg_dout)
);

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input logic reset_req,
	output logic clk,
	output logic n_reset
);

logic [2:0] low_left;

initial begin
	clk = 1'b0;
	n_reset = 1'b0;
	low_left = 3'd5;
end

always #10 clk = ~clk;

// Request is sampled on the rising edge, reset moves on the falling edge
always @(posedge clk)
	if (reset_req)
		low_left <= 3'd5;
	else if (low_left != 3'd0)
		low_left <= low_left - 3'd1;

always @(negedge clk)
	n_reset <= (low_left == 3'd0);

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input logic clk, n_reset,
	input cpu_pkg::cpu_bus_t bus,
	input logic sync, ready, halt,
	input logic dbg_shift, dbg_dout,
	input logic [63:0] name,
	input logic stalls,
	input logic [47:0] exp_writes,
	input logic [39:0] exp_snap,
	output int write_count,
	output logic scan_done,
	output int errors
);

logic [39:0] scan_bits;
int scan_count, vec_phase;
logic [15:0] last_addr;
logic last_rw, stalled;

initial errors = 0;

task automatic compare(input string what, input logic [39:0] expected, input logic [39:0] actual);
	if (expected !== actual) begin
		errors++;
		$display("** Error %s (stalls %0d) %s: expected %h actual %h",
			name, stalls, what, expected, actual);
	end
endtask

always @(posedge clk)
	if (!n_reset) begin
		write_count <= 0;
		scan_count <= 0;
		scan_done <= 1'b0;
		vec_phase <= 0;
		stalled <= 1'b0;
	end else begin
		// Address and rw must hold through a wait state
		if (stalled)
			compare("stall hold", {23'h0, last_addr, last_rw}, {23'h0, bus.addr, bus.rw});
		stalled <= bus.rw && (!ready || (halt && sync));
		last_addr <= bus.addr;
		last_rw <= bus.rw;

		// Reset vector reads, then first opcode fetch
		if (vec_phase == 0 || (vec_phase < 3 && bus.addr != last_addr)) begin
			case (vec_phase)
			0: compare("vector low", {24'h0, 16'hfffc}, {24'h0, bus.addr});
			1: compare("vector high", {24'h0, 16'hfffd}, {24'h0, bus.addr});
			default: compare("first fetch", {23'h0, 1'b1, 16'h0200}, {23'h0, sync, bus.addr});
			endcase
			vec_phase <= vec_phase + 1;
		end

		if (!bus.rw) begin
			if (write_count >= 2) begin
				errors++;
				$display("%s: unexpected extra write cycle at address %h", name, bus.addr);
			end else
				compare("write", {16'h0, exp_writes[47 - 24 * write_count -: 24]},
					{16'h0, bus.addr, bus.data});
			write_count <= write_count + 1;
		end

		if (dbg_shift && scan_count < 40) begin
			scan_bits <= {scan_bits[38:0], dbg_dout};
			scan_count <= scan_count + 1;
			if (scan_count == 39) begin
				compare("scan", exp_snap, {scan_bits[38:0], dbg_dout});
				scan_done <= 1'b1;
			end
		end
	end

endmodule

//--- testbench/tb_cpu_system.sv
`timescale 1ns/1ps

module tb_cpu_system;

import cpu_pkg::*;

localparam int ROWS = 4;

logic clk, n_reset, reset_req;
logic ready, halt, dbg_load, dbg_shift, stalls;
logic [7:0] data_in;
cpu_bus_t bus;
logic sync, dbg_dout, scan_done;
int write_count, check_errors, cycles, limit, settled;
logic [1:0] row;
logic [31:0] rng;
logic [7:0] mem [65536];

// Per row: name, program at 0200, two writes {addr, data}, {jmp addr, a, x, p}
logic [63:0] names [ROWS];
logic [159:0] progs [ROWS];
int lens [ROWS];
logic [47:0] writes [ROWS];
logic [39:0] snaps [ROWS];

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] v;
	v = s ^ (s << 13);
	v = v ^ (v >> 17);
	v = v ^ (v << 5);
	return v;
endfunction

task automatic load_program(input logic [1:0] r);
	for (int i = 0; i < 20; i++)
		mem[16'h0200 + 16'(i)] = progs[r][159 - 8 * i -: 8];
	mem[16'hfffc] = 8'h00;
	mem[16'hfffd] = 8'h02;
endtask

tb_clock clock_inst (.reset_req(reset_req), .clk(clk), .n_reset(n_reset));

cpu_system cpu_system_inst (
	.clk(clk),
	.n_reset(n_reset),
	.ready(ready),
	.halt(halt),
	.data_in(data_in),
	.bus(bus),
	.sync(sync),
	.dbg_load(dbg_load),
	.dbg_shift(dbg_shift),
	.dbg_dout(dbg_dout)
);

tb_checker checker_inst (
	.clk(clk),
	.n_reset(n_reset),
	.bus(bus),
	.sync(sync),
	.ready(ready),
	.halt(halt),
	.dbg_shift(dbg_shift),
	.dbg_dout(dbg_dout),
	.name(names[row]),
	.stalls(stalls),
	.exp_writes(writes[row]),
	.exp_snap(snaps[row]),
	.write_count(write_count),
	.scan_done(scan_done),
	.errors(check_errors)
);

assign data_in = mem[bus.addr];

always @(posedge clk)
	if (n_reset && !bus.rw)
		mem[bus.addr] <= bus.data;

// About one cycle in three is a wait state
always @(negedge clk) begin
	rng <= xorshift(rng);
	ready <= !stalls || ((rng % 32'd3) != 32'd0);
end

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles > limit) begin
		$display("Timeout: no result after %0d cycles", cycles);
		$display("check errors: %0d", check_errors);
		$display("TEST FAILED");
		$finish;
	end
end

initial begin
	reset_req = 1'b1;
	ready = 1'b1;
	halt = 1'b0;
	dbg_load = 1'b0;
	dbg_shift = 1'b0;
	stalls = 1'b0;
	row = 2'd0;
	rng = 32'hd9cf_5616;
	cycles = 0;
	limit = 1 << 30;

	names[0] = "adc_cout";
	progs[0] = 160'ha9f0_1869_208d_0003_a280_8e01_034c_0d02_eaea_eaea;
	lens[0] = 16;
	writes[0] = {16'h0300, 8'h10, 16'h0301, 8'h80};
	snaps[0] = {16'h020d, 8'h10, 8'h80, 8'ha1};
	names[1] = "and_eorz";
	progs[1] = 160'ha233_a95a_290f_8d10_0349_0a8d_1103_4c0e_02ea_eaea;
	lens[1] = 17;
	writes[1] = {16'h0310, 8'h0a, 16'h0311, 8'h00};
	snaps[1] = {16'h020e, 8'h00, 8'h33, 8'h22};
	names[2] = "sec_adcn";
	progs[2] = 160'h38a9_7f69_008d_0004_a200_8e01_044c_0d02_eaea_eaea;
	lens[2] = 16;
	writes[2] = {16'h0400, 8'h80, 16'h0401, 8'h00};
	snaps[2] = {16'h020d, 8'h80, 8'h00, 8'h22};
	names[3] = "adc_wrap";
	progs[3] = 160'ha2c3_18a9_ff69_018d_0005_6900_8eff_054c_0f02_eaea;
	lens[3] = 18;
	writes[3] = {16'h0500, 8'h00, 16'h05ff, 8'hc3};
	snaps[3] = {16'h020f, 8'h01, 8'hc3, 8'h20};

	// Every row runs once clean and once with wait states
	limit = 0;
	for (int r = 0; r < ROWS; r++)
		limit += 2 * (lens[r] * 4 + 64);
	for (int i = 0; i < 65536; i++)
		mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;

	for (int run_no = 0; run_no < 2 * ROWS; run_no++) begin
		@(negedge clk);
		row = run_no[1:0];
		stalls = run_no[2];
		halt = 1'b0;
		reset_req = 1'b1;
		load_program(row);
		@(negedge clk);
		reset_req = 1'b0;
		@(posedge clk);
		while (!n_reset)
			@(posedge clk);
		@(negedge clk);
		while (write_count < 2)
			@(negedge clk);
		halt = 1'b1;
		// Wait for the core to sit at the JMP fetch
		settled = 0;
		while (settled < 2) begin
			@(negedge clk);
			if (sync && bus.addr == snaps[row][39:24])
				settled++;
			else
				settled = 0;
		end
		dbg_load = 1'b1;
		@(negedge clk);
		dbg_load = 1'b0;
		dbg_shift = 1'b1;
		while (!scan_done)
			@(negedge clk);
		dbg_shift = 1'b0;
	end

	@(negedge clk);
	$display("check errors: %0d", check_errors);
	if (check_errors == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

//--- src.f
design/cpu_pkg.sv
design/cpu_alu.sv
design/mop_sequencer.sv
design/cpu_core.sv
design/debug_scan.sv
design/cpu_system.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_cpu_system.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module tb_cpu_system

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_cpu_system -o tb_sim
	out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
